// File: hdl/pc_io_cfg.svh
`ifndef PC_IO_CFG_SVH
`define PC_IO_CFG_SVH

// port bases and the number of ignored low address bits per range.
`define PC_PORT_HDD0        16'h01F0
`define PC_MASK_HDD0        3
`define PC_PORT_HDD0_ALT    16'h03F6
`define PC_PORT_HDD1        16'h0170
`define PC_MASK_HDD1        3
`define PC_PORT_HDD1_ALT    16'h0376
`define PC_PORT_FLOPPY0     16'h03F0
`define PC_MASK_FLOPPY0     3
`define PC_PORT_DMA_MASTER  16'h00C0
`define PC_MASK_DMA_MASTER  5
`define PC_PORT_DMA_PAGE    16'h0080
`define PC_MASK_DMA_PAGE    4
`define PC_PORT_DMA_SLAVE   16'h0000
`define PC_MASK_DMA_SLAVE   4
`define PC_PORT_PIC_MASTER  16'h0020
`define PC_MASK_PIC_MASTER  1
`define PC_PORT_PIC_SLAVE   16'h00A0
`define PC_MASK_PIC_SLAVE   1
`define PC_PORT_PIT         16'h0040
`define PC_MASK_PIT         2
`define PC_PORT_PIT_ALT     16'h0061   // speaker gate port.
`define PC_PORT_PS2_IO      16'h0060
`define PC_MASK_PS2_IO      3
`define PC_PORT_PS2_CTL     16'h0090
`define PC_MASK_PS2_CTL     4
`define PC_PORT_JOY         16'h0201
`define PC_MASK_JOY         0
`define PC_PORT_RTC         16'h0070
`define PC_MASK_RTC         1
`define PC_PORT_FM          16'h0388
`define PC_MASK_FM          2
`define PC_PORT_SB          16'h0220
`define PC_MASK_SB          4
`define PC_PORT_UART        16'h03F8
`define PC_MASK_UART        3
`define PC_PORT_MPU         16'h0330
`define PC_MASK_MPU         1
`define PC_PORT_VGA_B       16'h03B0
`define PC_MASK_VGA_B       4
`define PC_PORT_VGA_C       16'h03C0
`define PC_MASK_VGA_C       4
`define PC_PORT_VGA_D       16'h03D0
`define PC_MASK_VGA_D       4
`define PC_PORT_SYSCTL      16'h8888
`define PC_MASK_SYSCTL      0

// bit positions in io_sel.
`define PC_SEL_HDD0         0
`define PC_SEL_HDD1         1
`define PC_SEL_FLOPPY0      2
`define PC_SEL_DMA_MASTER   3
`define PC_SEL_DMA_PAGE     4
`define PC_SEL_DMA_SLAVE    5
`define PC_SEL_PIC_MASTER   6
`define PC_SEL_PIC_SLAVE    7
`define PC_SEL_PIT          8
`define PC_SEL_PS2_IO       9
`define PC_SEL_PS2_CTL      10
`define PC_SEL_JOY          11
`define PC_SEL_RTC          12
`define PC_SEL_FM           13
`define PC_SEL_SB           14
`define PC_SEL_UART         15
`define PC_SEL_MPU          16
`define PC_SEL_VGA_B        17
`define PC_SEL_VGA_C        18
`define PC_SEL_VGA_D        19
`define PC_SEL_SYSCTL       20

`define PC_SYSCFG_RESET     8'hA2
`define PC_SYSCFG_KEY       8'hA1   // expected in write data bits 15:8.

// device codes in the upper management address byte.
`define PC_MGMT_HDD0        8'hF0
`define PC_MGMT_HDD1        8'hF1
`define PC_MGMT_FDD0        8'hF2
`define PC_MGMT_RTC         8'hF4

`endif

// File: hdl/pc_io_pkg.sv
package pc_io_pkg;

	// i/o bus.
	typedef logic [15:0] io_addr_t;
	typedef logic [31:0] io_data_t;
	typedef logic [7:0]  io_byte_t;   // read data of the 8-bit devices.
	typedef logic [2:0]  io_size_t;   // transfer size in bytes.

	// one bit per decoded port range, see PC_SEL_* for positions.
	typedef logic [20:0] io_sel_t;

	// pic inputs.
	typedef logic [15:0] irq_vec_t;

	// management bus.
	typedef logic [15:0] mgmt_addr_t;
	typedef logic [31:0] mgmt_data_t;

	typedef logic [7:0]  syscfg_t;    // written through the system control port.

endpackage

// File: hdl/io_port_decode.sv
`timescale 1ns/1ns
`include "pc_io_cfg.svh"

module io_port_decode (
	input  logic                 clk_sys,
	input  logic                 reset_cpu,
	input  pc_io_pkg::io_addr_t  iobus_address,
	output pc_io_pkg::io_sel_t   io_sel
);
	import pc_io_pkg::*;

	io_sel_t sel_next;

	// true when addr matches base with the low mask bits ignored.
	function automatic logic base_match(input io_addr_t addr, input io_addr_t base,
		input int unsigned mask);
		return (addr >> mask) == (base >> mask);
	endfunction

	always_comb begin
		sel_next = '0;
		sel_next[`PC_SEL_HDD0]       = base_match(iobus_address, `PC_PORT_HDD0, `PC_MASK_HDD0)
			|| (iobus_address == `PC_PORT_HDD0_ALT);
		sel_next[`PC_SEL_HDD1]       = base_match(iobus_address, `PC_PORT_HDD1, `PC_MASK_HDD1)
			|| (iobus_address == `PC_PORT_HDD1_ALT);
		sel_next[`PC_SEL_FLOPPY0]    = base_match(iobus_address, `PC_PORT_FLOPPY0,
			`PC_MASK_FLOPPY0);
		sel_next[`PC_SEL_DMA_MASTER] = base_match(iobus_address, `PC_PORT_DMA_MASTER,
			`PC_MASK_DMA_MASTER);
		sel_next[`PC_SEL_DMA_PAGE]   = base_match(iobus_address, `PC_PORT_DMA_PAGE,
			`PC_MASK_DMA_PAGE);
		sel_next[`PC_SEL_DMA_SLAVE]  = base_match(iobus_address, `PC_PORT_DMA_SLAVE,
			`PC_MASK_DMA_SLAVE);
		sel_next[`PC_SEL_PIC_MASTER] = base_match(iobus_address, `PC_PORT_PIC_MASTER,
			`PC_MASK_PIC_MASTER);
		sel_next[`PC_SEL_PIC_SLAVE]  = base_match(iobus_address, `PC_PORT_PIC_SLAVE,
			`PC_MASK_PIC_SLAVE);
		sel_next[`PC_SEL_PIT]        = base_match(iobus_address, `PC_PORT_PIT, `PC_MASK_PIT)
			|| (iobus_address == `PC_PORT_PIT_ALT);
		sel_next[`PC_SEL_PS2_IO]     = base_match(iobus_address, `PC_PORT_PS2_IO,
			`PC_MASK_PS2_IO);
		sel_next[`PC_SEL_PS2_CTL]    = base_match(iobus_address, `PC_PORT_PS2_CTL,
			`PC_MASK_PS2_CTL);
		sel_next[`PC_SEL_JOY]        = base_match(iobus_address, `PC_PORT_JOY, `PC_MASK_JOY);
		sel_next[`PC_SEL_RTC]        = base_match(iobus_address, `PC_PORT_RTC, `PC_MASK_RTC);
		sel_next[`PC_SEL_FM]         = base_match(iobus_address, `PC_PORT_FM, `PC_MASK_FM);
		sel_next[`PC_SEL_SB]         = base_match(iobus_address, `PC_PORT_SB, `PC_MASK_SB);
		sel_next[`PC_SEL_UART]       = base_match(iobus_address, `PC_PORT_UART, `PC_MASK_UART);
		sel_next[`PC_SEL_MPU]        = base_match(iobus_address, `PC_PORT_MPU, `PC_MASK_MPU);
		sel_next[`PC_SEL_VGA_B]      = base_match(iobus_address, `PC_PORT_VGA_B,
			`PC_MASK_VGA_B);
		sel_next[`PC_SEL_VGA_C]      = base_match(iobus_address, `PC_PORT_VGA_C,
			`PC_MASK_VGA_C);
		sel_next[`PC_SEL_VGA_D]      = base_match(iobus_address, `PC_PORT_VGA_D,
			`PC_MASK_VGA_D);
		sel_next[`PC_SEL_SYSCTL]     = base_match(iobus_address, `PC_PORT_SYSCTL,
			`PC_MASK_SYSCTL);
	end

	// selects lag the address by one clock.
	always_ff @(posedge clk_sys) begin
		if (reset_cpu) begin
			io_sel <= '0;
		end else begin
			io_sel <= sel_next;
		end
	end

endmodule

// File: hdl/sysctl_port.sv
`timescale 1ns/1ns
`include "pc_io_cfg.svh"

module sysctl_port (
	input  logic                 clk_sys,
	input  logic                 reset_cpu,
	input  pc_io_pkg::io_sel_t   io_sel,
	input  logic                 iobus_write,
	input  pc_io_pkg::io_size_t  iobus_datasize,
	input  pc_io_pkg::io_data_t  iobus_writedata,
	output pc_io_pkg::syscfg_t   syscfg
);

	logic first_access;   // open from reset until the first disk access or keyed write.
	logic disk_sel;
	logic key_write;

	assign disk_sel = io_sel[`PC_SEL_HDD0] | io_sel[`PC_SEL_HDD1] | io_sel[`PC_SEL_FLOPPY0];

	// only a 16-bit write carrying the key in its high byte loads the register.
	assign key_write = iobus_write && io_sel[`PC_SEL_SYSCTL] && (iobus_datasize == 3'd2)
		&& (iobus_writedata[15:8] == `PC_SYSCFG_KEY);

	always_ff @(posedge clk_sys) begin
		if (reset_cpu) begin
			syscfg       <= `PC_SYSCFG_RESET;
			first_access <= 1'b1;
		end else if (first_access && disk_sel) begin
			syscfg       <= '0;   // boot has reached the drives.
			first_access <= 1'b0;
		end else if (key_write) begin
			syscfg       <= iobus_writedata[7:0];
			first_access <= 1'b0;
		end
	end

endmodule

// File: hdl/io_read_mux.sv
`timescale 1ns/1ns
`include "pc_io_cfg.svh"

module io_read_mux (
	input  pc_io_pkg::io_sel_t   io_sel,
	input  pc_io_pkg::io_addr_t  iobus_address,
	input  pc_io_pkg::io_data_t  hdd0_readdata,
	input  pc_io_pkg::io_data_t  hdd1_readdata,
	input  pc_io_pkg::io_byte_t  floppy0_readdata,
	input  pc_io_pkg::io_byte_t  dma_readdata,
	input  pc_io_pkg::io_byte_t  pic_readdata,
	input  pc_io_pkg::io_byte_t  pit_readdata,
	input  pc_io_pkg::io_byte_t  ps2_readdata,
	input  pc_io_pkg::io_byte_t  rtc_readdata,
	input  pc_io_pkg::io_byte_t  sound_readdata,
	input  pc_io_pkg::io_byte_t  uart_readdata,
	input  pc_io_pkg::io_byte_t  vga_readdata,
	input  pc_io_pkg::io_byte_t  joy_readdata,
	output pc_io_pkg::io_data_t  bus_readdata,
	output logic                 bus_io32
);
	import pc_io_pkg::*;

	io_byte_t readdata8;
	logic     disk_sel;

	always_comb begin
		if (io_sel[`PC_SEL_FLOPPY0])
			readdata8 = floppy0_readdata;
		else if (io_sel[`PC_SEL_DMA_MASTER] | io_sel[`PC_SEL_DMA_SLAVE] | io_sel[`PC_SEL_DMA_PAGE])
			readdata8 = dma_readdata;
		else if (io_sel[`PC_SEL_PIC_MASTER] | io_sel[`PC_SEL_PIC_SLAVE])
			readdata8 = pic_readdata;
		else if (io_sel[`PC_SEL_PIT])
			readdata8 = pit_readdata;
		else if (io_sel[`PC_SEL_PS2_IO] | io_sel[`PC_SEL_PS2_CTL])
			readdata8 = ps2_readdata;
		else if (io_sel[`PC_SEL_RTC])
			readdata8 = rtc_readdata;
		else if (io_sel[`PC_SEL_FM] | io_sel[`PC_SEL_SB])
			readdata8 = sound_readdata;
		else if (io_sel[`PC_SEL_UART] | io_sel[`PC_SEL_MPU])
			readdata8 = uart_readdata;
		else if (io_sel[`PC_SEL_VGA_B] | io_sel[`PC_SEL_VGA_C] | io_sel[`PC_SEL_VGA_D])
			readdata8 = vga_readdata;
		else if (io_sel[`PC_SEL_JOY])
			readdata8 = joy_readdata;
		else
			readdata8 = 8'hFF;   // open bus.
	end

	// disks answer with full words ahead of everything else.
	always_comb begin
		if (io_sel[`PC_SEL_HDD0])
			bus_readdata = hdd0_readdata;
		else if (io_sel[`PC_SEL_HDD1])
			bus_readdata = hdd1_readdata;
		else
			bus_readdata = {24'd0, readdata8};
	end

	assign disk_sel = io_sel[`PC_SEL_HDD0] | io_sel[`PC_SEL_HDD1];

	// bit 9 set means the alternate status port, which stays 8-bit.
	assign bus_io32 = (disk_sel & ~iobus_address[9]) | io_sel[`PC_SEL_SYSCTL];

endmodule

// File: hdl/mgmt_target_decode.sv
`timescale 1ns/1ns
`include "pc_io_cfg.svh"

module mgmt_target_decode (
	input  logic                   clk_sys,
	input  logic                   reset_cpu,
	input  pc_io_pkg::mgmt_addr_t  mgmt_ctl_address,
	input  logic                   mgmt_ctl_read,
	input  logic                   mgmt_ctl_write,
	input  pc_io_pkg::mgmt_data_t  mgmt_hdd0_readdata,
	input  pc_io_pkg::mgmt_data_t  mgmt_hdd1_readdata,
	input  pc_io_pkg::mgmt_data_t  mgmt_fdd0_readdata,
	output logic                   mgmt_hdd0_read,
	output logic                   mgmt_hdd0_write,
	output logic                   mgmt_hdd1_read,
	output logic                   mgmt_hdd1_write,
	output logic                   mgmt_fdd0_read,
	output logic                   mgmt_fdd0_write,
	output logic                   mgmt_rtc_write,
	output pc_io_pkg::mgmt_data_t  mgmt_readdata
);

	logic hdd0_sel;
	logic hdd1_sel;
	logic fdd0_sel;
	logic rtc_sel;

	// device code sits in the upper address byte.
	always_ff @(posedge clk_sys) begin
		if (reset_cpu) begin
			hdd0_sel <= 1'b0;
			hdd1_sel <= 1'b0;
			fdd0_sel <= 1'b0;
			rtc_sel  <= 1'b0;
		end else begin
			hdd0_sel <= (mgmt_ctl_address[15:8] == `PC_MGMT_HDD0);
			hdd1_sel <= (mgmt_ctl_address[15:8] == `PC_MGMT_HDD1);
			fdd0_sel <= (mgmt_ctl_address[15:8] == `PC_MGMT_FDD0);
			rtc_sel  <= (mgmt_ctl_address[15:8] == `PC_MGMT_RTC);
		end
	end

	assign mgmt_hdd0_read  = mgmt_ctl_read  & hdd0_sel;
	assign mgmt_hdd0_write = mgmt_ctl_write & hdd0_sel;
	assign mgmt_hdd1_read  = mgmt_ctl_read  & hdd1_sel;
	assign mgmt_hdd1_write = mgmt_ctl_write & hdd1_sel;
	assign mgmt_fdd0_read  = mgmt_ctl_read  & fdd0_sel;
	assign mgmt_fdd0_write = mgmt_ctl_write & fdd0_sel;
	assign mgmt_rtc_write  = mgmt_ctl_write & rtc_sel;   // rtc has no read-back.

	// floppy data is the fallback when neither disk is selected.
	always_comb begin
		if (hdd0_sel)
			mgmt_readdata = mgmt_hdd0_readdata;
		else if (hdd1_sel)
			mgmt_readdata = mgmt_hdd1_readdata;
		else
			mgmt_readdata = mgmt_fdd0_readdata;
	end

endmodule

// File: hdl/pc_io_hub.sv
`timescale 1ns/1ns

module pc_io_hub (
	input  logic                   clk_sys,
	input  logic                   reset_cpu,

	input  pc_io_pkg::io_addr_t    iobus_address,
	input  logic                   iobus_write,
	input  pc_io_pkg::io_size_t    iobus_datasize,
	input  pc_io_pkg::io_data_t    iobus_writedata,

	input  pc_io_pkg::io_data_t    hdd0_readdata,
	input  pc_io_pkg::io_data_t    hdd1_readdata,
	input  pc_io_pkg::io_byte_t    floppy0_readdata,
	input  pc_io_pkg::io_byte_t    dma_readdata,
	input  pc_io_pkg::io_byte_t    pic_readdata,
	input  pc_io_pkg::io_byte_t    pit_readdata,
	input  pc_io_pkg::io_byte_t    ps2_readdata,
	input  pc_io_pkg::io_byte_t    rtc_readdata,
	input  pc_io_pkg::io_byte_t    sound_readdata,
	input  pc_io_pkg::io_byte_t    uart_readdata,
	input  pc_io_pkg::io_byte_t    vga_readdata,
	input  pc_io_pkg::io_byte_t    joy_readdata,

	output pc_io_pkg::io_sel_t     io_sel,
	output pc_io_pkg::io_data_t    bus_readdata,
	output logic                   bus_io32,
	output pc_io_pkg::syscfg_t     syscfg,

	input  logic                   irq_0,
	input  logic                   irq_1,
	input  logic                   irq_2,
	input  logic                   irq_4,
	input  logic                   irq_5,
	input  logic                   irq_6,
	input  logic                   irq_8,
	input  logic                   irq_9,
	input  logic                   irq_12,
	input  logic                   irq_14,
	input  logic                   irq_15,
	output pc_io_pkg::irq_vec_t    irq_vec,

	input  pc_io_pkg::mgmt_addr_t  mgmt_ctl_address,
	input  logic                   mgmt_ctl_read,
	input  logic                   mgmt_ctl_write,
	input  pc_io_pkg::mgmt_data_t  mgmt_hdd0_readdata,
	input  pc_io_pkg::mgmt_data_t  mgmt_hdd1_readdata,
	input  pc_io_pkg::mgmt_data_t  mgmt_fdd0_readdata,
	output logic                   mgmt_hdd0_read,
	output logic                   mgmt_hdd0_write,
	output logic                   mgmt_hdd1_read,
	output logic                   mgmt_hdd1_write,
	output logic                   mgmt_fdd0_read,
	output logic                   mgmt_fdd0_write,
	output logic                   mgmt_rtc_write,
	output pc_io_pkg::mgmt_data_t  mgmt_readdata
);

	io_port_decode decode0 (
		.clk_sys        (clk_sys),
		.reset_cpu      (reset_cpu),
		.iobus_address  (iobus_address),
		.io_sel         (io_sel)
	);

	sysctl_port sysctl0 (
		.clk_sys          (clk_sys),
		.reset_cpu        (reset_cpu),
		.io_sel           (io_sel),
		.iobus_write      (iobus_write),
		.iobus_datasize   (iobus_datasize),
		.iobus_writedata  (iobus_writedata),
		.syscfg           (syscfg)
	);

	io_read_mux rdmux0 (
		.io_sel            (io_sel),
		.iobus_address     (iobus_address),
		.hdd0_readdata     (hdd0_readdata),
		.hdd1_readdata     (hdd1_readdata),
		.floppy0_readdata  (floppy0_readdata),
		.dma_readdata      (dma_readdata),
		.pic_readdata      (pic_readdata),
		.pit_readdata      (pit_readdata),
		.ps2_readdata      (ps2_readdata),
		.rtc_readdata      (rtc_readdata),
		.sound_readdata    (sound_readdata),
		.uart_readdata     (uart_readdata),
		.vga_readdata      (vga_readdata),
		.joy_readdata      (joy_readdata),
		.bus_readdata      (bus_readdata),
		.bus_io32          (bus_io32)
	);

	mgmt_target_decode mgmt0 (
		.clk_sys             (clk_sys),
		.reset_cpu           (reset_cpu),
		.mgmt_ctl_address    (mgmt_ctl_address),
		.mgmt_ctl_read       (mgmt_ctl_read),
		.mgmt_ctl_write      (mgmt_ctl_write),
		.mgmt_hdd0_readdata  (mgmt_hdd0_readdata),
		.mgmt_hdd1_readdata  (mgmt_hdd1_readdata),
		.mgmt_fdd0_readdata  (mgmt_fdd0_readdata),
		.mgmt_hdd0_read      (mgmt_hdd0_read),
		.mgmt_hdd0_write     (mgmt_hdd0_write),
		.mgmt_hdd1_read      (mgmt_hdd1_read),
		.mgmt_hdd1_write     (mgmt_hdd1_write),
		.mgmt_fdd0_read      (mgmt_fdd0_read),
		.mgmt_fdd0_write     (mgmt_fdd0_write),
		.mgmt_rtc_write      (mgmt_rtc_write),
		.mgmt_readdata       (mgmt_readdata)
	);

	// pic inputs. the cascade line 2 is not a device input, so vga irq 2 lands on 9.
	always_comb begin
		irq_vec     = '0;
		irq_vec[0]  = irq_0;
		irq_vec[1]  = irq_1;
		irq_vec[4]  = irq_4;
		irq_vec[5]  = irq_5;
		irq_vec[6]  = irq_6;
		irq_vec[8]  = irq_8;
		irq_vec[9]  = irq_9 | irq_2;
		irq_vec[12] = irq_12;
		irq_vec[14] = irq_14;
		irq_vec[15] = irq_15;
	end

endmodule

// File: sim/pc_io_hub_asserts.sv
`timescale 1ns/1ns
`include "pc_io_cfg.svh"

module pc_io_hub_asserts (
	input logic                   clk_sys, reset_cpu,
	input pc_io_pkg::io_addr_t    iobus_address,
	input logic                   iobus_write,
	input pc_io_pkg::io_size_t    iobus_datasize,
	input pc_io_pkg::io_data_t    iobus_writedata, hdd0_readdata, hdd1_readdata, bus_readdata,
	input pc_io_pkg::io_byte_t    floppy0_readdata, dma_readdata, pic_readdata, pit_readdata,
		ps2_readdata, rtc_readdata, sound_readdata, uart_readdata, vga_readdata, joy_readdata,
	input pc_io_pkg::io_sel_t     io_sel,
	input logic                   bus_io32,
	input pc_io_pkg::syscfg_t     syscfg,
	input logic                   irq_0, irq_1, irq_2, irq_4, irq_5, irq_6, irq_8, irq_9,
		irq_12, irq_14, irq_15,
	input pc_io_pkg::irq_vec_t    irq_vec,
	input pc_io_pkg::mgmt_addr_t  mgmt_ctl_address,
	input logic                   mgmt_ctl_read, mgmt_ctl_write, mgmt_hdd0_read, mgmt_hdd0_write,
		mgmt_hdd1_read, mgmt_hdd1_write, mgmt_fdd0_read, mgmt_fdd0_write, mgmt_rtc_write,
	input pc_io_pkg::mgmt_data_t  mgmt_hdd0_readdata, mgmt_hdd1_readdata, mgmt_fdd0_readdata,
		mgmt_readdata
);
	import pc_io_pkg::*;

	io_sel_t     sel_exp;   // expected selects for the previous address.
	logic        rst_q;
	logic [7:0]  mdev_q;
	logic        win;
	logic        disk_hit;
	logic        keyed;
	syscfg_t     cfg_exp;
	io_data_t    rd_exp;
	logic        io32_exp;
	irq_vec_t    irq_exp;
	logic [6:0]  mstb;
	logic [6:0]  mstb_exp;
	mgmt_data_t  mrd_exp;
	int          fail_count = 0;
	string       fail_name;
	logic [31:0] fail_got;
	logic [31:0] fail_exp;

	function automatic logic hit(input io_addr_t a, input io_addr_t base, input int m);
		io_addr_t keep;
		keep = 16'hFFFF << m;
		return (a & keep) == base;
	endfunction

	function automatic io_sel_t exp_sel(input io_addr_t a);
		io_sel_t s;
		s = '0;
		s[`PC_SEL_HDD0]       = hit(a, `PC_PORT_HDD0, `PC_MASK_HDD0) || a == `PC_PORT_HDD0_ALT;
		s[`PC_SEL_HDD1]       = hit(a, `PC_PORT_HDD1, `PC_MASK_HDD1) || a == `PC_PORT_HDD1_ALT;
		s[`PC_SEL_FLOPPY0]    = hit(a, `PC_PORT_FLOPPY0, `PC_MASK_FLOPPY0);
		s[`PC_SEL_DMA_MASTER] = hit(a, `PC_PORT_DMA_MASTER, `PC_MASK_DMA_MASTER);
		s[`PC_SEL_DMA_PAGE]   = hit(a, `PC_PORT_DMA_PAGE, `PC_MASK_DMA_PAGE);
		s[`PC_SEL_DMA_SLAVE]  = hit(a, `PC_PORT_DMA_SLAVE, `PC_MASK_DMA_SLAVE);
		s[`PC_SEL_PIC_MASTER] = hit(a, `PC_PORT_PIC_MASTER, `PC_MASK_PIC_MASTER);
		s[`PC_SEL_PIC_SLAVE]  = hit(a, `PC_PORT_PIC_SLAVE, `PC_MASK_PIC_SLAVE);
		s[`PC_SEL_PIT]        = hit(a, `PC_PORT_PIT, `PC_MASK_PIT) || a == `PC_PORT_PIT_ALT;
		s[`PC_SEL_PS2_IO]     = hit(a, `PC_PORT_PS2_IO, `PC_MASK_PS2_IO);
		s[`PC_SEL_PS2_CTL]    = hit(a, `PC_PORT_PS2_CTL, `PC_MASK_PS2_CTL);
		s[`PC_SEL_JOY]        = hit(a, `PC_PORT_JOY, `PC_MASK_JOY);
		s[`PC_SEL_RTC]        = hit(a, `PC_PORT_RTC, `PC_MASK_RTC);
		s[`PC_SEL_FM]         = hit(a, `PC_PORT_FM, `PC_MASK_FM);
		s[`PC_SEL_SB]         = hit(a, `PC_PORT_SB, `PC_MASK_SB);
		s[`PC_SEL_UART]       = hit(a, `PC_PORT_UART, `PC_MASK_UART);
		s[`PC_SEL_MPU]        = hit(a, `PC_PORT_MPU, `PC_MASK_MPU);
		s[`PC_SEL_VGA_B]      = hit(a, `PC_PORT_VGA_B, `PC_MASK_VGA_B);
		s[`PC_SEL_VGA_C]      = hit(a, `PC_PORT_VGA_C, `PC_MASK_VGA_C);
		s[`PC_SEL_VGA_D]      = hit(a, `PC_PORT_VGA_D, `PC_MASK_VGA_D);
		s[`PC_SEL_SYSCTL]     = hit(a, `PC_PORT_SYSCTL, `PC_MASK_SYSCTL);
		return s;
	endfunction

	task automatic flag(input string name, input logic [31:0] got, input logic [31:0] exp);
		fail_count++;
		fail_name = name;
		fail_got  = got;
		fail_exp  = exp;
		$error("%s: got %h, expected %h", name, got, exp);
	endtask

	always_ff @(posedge clk_sys) begin
		rst_q  <= reset_cpu;
		mdev_q <= mgmt_ctl_address[15:8];
		if (reset_cpu)
			sel_exp <= '0;
		else
			sel_exp <= exp_sel(iobus_address);
	end

	assign disk_hit = sel_exp[`PC_SEL_HDD0] | sel_exp[`PC_SEL_HDD1] | sel_exp[`PC_SEL_FLOPPY0];
	assign keyed = iobus_write & sel_exp[`PC_SEL_SYSCTL] & (iobus_datasize == 3'd2)
		& (iobus_writedata[15:8] == `PC_SYSCFG_KEY);

	// reference for the config byte.
	always_ff @(posedge clk_sys) begin
		if (reset_cpu) begin
			cfg_exp <= `PC_SYSCFG_RESET;
			win     <= 1'b1;
		end else if (win && disk_hit) begin
			cfg_exp <= '0;
			win     <= 1'b0;
		end else if (keyed) begin
			cfg_exp <= iobus_writedata[7:0];
			win     <= 1'b0;
		end
	end

	// lowest priority first, later lines override.
	always_comb begin
		rd_exp = 32'h0000_00FF;
		if (sel_exp[`PC_SEL_JOY]) rd_exp = {24'd0, joy_readdata};
		if (|{sel_exp[`PC_SEL_VGA_B], sel_exp[`PC_SEL_VGA_C], sel_exp[`PC_SEL_VGA_D]})
			rd_exp = {24'd0, vga_readdata};
		if (sel_exp[`PC_SEL_UART] | sel_exp[`PC_SEL_MPU])
			rd_exp = {24'd0, uart_readdata};
		if (sel_exp[`PC_SEL_FM] | sel_exp[`PC_SEL_SB])
			rd_exp = {24'd0, sound_readdata};
		if (sel_exp[`PC_SEL_RTC]) rd_exp = {24'd0, rtc_readdata};
		if (sel_exp[`PC_SEL_PS2_IO] | sel_exp[`PC_SEL_PS2_CTL])
			rd_exp = {24'd0, ps2_readdata};
		if (sel_exp[`PC_SEL_PIT]) rd_exp = {24'd0, pit_readdata};
		if (sel_exp[`PC_SEL_PIC_MASTER] | sel_exp[`PC_SEL_PIC_SLAVE])
			rd_exp = {24'd0, pic_readdata};
		if (|{sel_exp[`PC_SEL_DMA_MASTER], sel_exp[`PC_SEL_DMA_PAGE],
			sel_exp[`PC_SEL_DMA_SLAVE]})
			rd_exp = {24'd0, dma_readdata};
		if (sel_exp[`PC_SEL_FLOPPY0]) rd_exp = {24'd0, floppy0_readdata};
		if (sel_exp[`PC_SEL_HDD1]) rd_exp = hdd1_readdata;
		if (sel_exp[`PC_SEL_HDD0]) rd_exp = hdd0_readdata;
	end

	assign io32_exp = ((sel_exp[`PC_SEL_HDD0] | sel_exp[`PC_SEL_HDD1]) & ~iobus_address[9])
		| sel_exp[`PC_SEL_SYSCTL];
	assign irq_exp = {irq_15, irq_14, 1'b0, irq_12, 2'b00, irq_9 | irq_2, irq_8, 1'b0,
		irq_6, irq_5, irq_4, 2'b00, irq_1, irq_0};   // line 2 folds into 9.

	assign mstb = {mgmt_hdd0_read, mgmt_hdd0_write, mgmt_hdd1_read, mgmt_hdd1_write,
		mgmt_fdd0_read, mgmt_fdd0_write, mgmt_rtc_write};
	assign mstb_exp = {{2{mdev_q == `PC_MGMT_HDD0}}, {2{mdev_q == `PC_MGMT_HDD1}},
		{2{mdev_q == `PC_MGMT_FDD0}}, mdev_q == `PC_MGMT_RTC}
		& {{3{mgmt_ctl_read, mgmt_ctl_write}}, mgmt_ctl_write};
	assign mrd_exp = (mdev_q == `PC_MGMT_HDD0) ? mgmt_hdd0_readdata
		: (mdev_q == `PC_MGMT_HDD1) ? mgmt_hdd1_readdata : mgmt_fdd0_readdata;

	a_reset: assert property (@(posedge clk_sys)
		rst_q && !reset_cpu |-> io_sel == '0 && mstb == '0)
		else flag("io_sel/mgmt strobes after reset", {$sampled(mstb), $sampled(io_sel)}, 0);
	a_sel: assert property (@(posedge clk_sys) disable iff (reset_cpu)
		!rst_q |-> io_sel == sel_exp)
		else flag("io_sel", $sampled(io_sel), $sampled(sel_exp));
	a_rd: assert property (@(posedge clk_sys) disable iff (reset_cpu)
		bus_readdata == rd_exp)
		else flag("bus_readdata", $sampled(bus_readdata), $sampled(rd_exp));
	a_io32: assert property (@(posedge clk_sys) disable iff (reset_cpu)
		bus_io32 == io32_exp)
		else flag("bus_io32", $sampled(bus_io32), $sampled(io32_exp));
	a_cfg: assert property (@(posedge clk_sys) disable iff (reset_cpu)
		syscfg == cfg_exp)
		else flag("syscfg", $sampled(syscfg), $sampled(cfg_exp));
	a_irq: assert property (@(posedge clk_sys) irq_vec == irq_exp)
		else flag("irq_vec", $sampled(irq_vec), $sampled(irq_exp));
	a_mstb: assert property (@(posedge clk_sys) disable iff (reset_cpu)
		!rst_q |-> mstb == mstb_exp)
		else flag("mgmt strobes", $sampled(mstb), $sampled(mstb_exp));
	a_mrd: assert property (@(posedge clk_sys) disable iff (reset_cpu)
		!rst_q |-> mgmt_readdata == mrd_exp)
		else flag("mgmt_readdata", $sampled(mgmt_readdata), $sampled(mrd_exp));

endmodule

bind pc_io_hub pc_io_hub_asserts asrt0 (.*);

// File: sim/tb_pc_io_hub.sv
`timescale 1ns/1ns
`include "pc_io_cfg.svh"

module tb_pc_io_hub;
	import pc_io_pkg::*;

	logic        clk_sys;
	logic        reset_cpu;
	io_addr_t    iobus_address;
	logic        iobus_write;
	io_size_t    iobus_datasize;
	io_data_t    iobus_writedata, hdd0_readdata, hdd1_readdata, bus_readdata;
	io_byte_t    floppy0_readdata, dma_readdata, pic_readdata, pit_readdata, ps2_readdata;
	io_byte_t    rtc_readdata, sound_readdata, uart_readdata, vga_readdata, joy_readdata;
	io_sel_t     io_sel;
	logic        bus_io32;
	syscfg_t     syscfg;
	logic        irq_0, irq_1, irq_2, irq_4, irq_5, irq_6, irq_8, irq_9, irq_12, irq_14, irq_15;
	irq_vec_t    irq_vec;
	mgmt_addr_t  mgmt_ctl_address;
	logic        mgmt_ctl_read, mgmt_ctl_write;
	mgmt_data_t  mgmt_hdd0_readdata, mgmt_hdd1_readdata, mgmt_fdd0_readdata, mgmt_readdata;
	logic        mgmt_hdd0_read, mgmt_hdd0_write, mgmt_hdd1_read, mgmt_hdd1_write;
	logic        mgmt_fdd0_read, mgmt_fdd0_write, mgmt_rtc_write;
	logic [31:0] rng;

	io_addr_t bases [24] = '{`PC_PORT_HDD0, `PC_PORT_HDD0_ALT, `PC_PORT_HDD1, `PC_PORT_HDD1_ALT,
		`PC_PORT_FLOPPY0, `PC_PORT_DMA_MASTER, `PC_PORT_DMA_PAGE, `PC_PORT_DMA_SLAVE,
		`PC_PORT_PIC_MASTER, `PC_PORT_PIC_SLAVE, `PC_PORT_PIT, `PC_PORT_PIT_ALT,
		`PC_PORT_PS2_IO, `PC_PORT_PS2_CTL, `PC_PORT_JOY, `PC_PORT_RTC, `PC_PORT_FM, `PC_PORT_SB,
		`PC_PORT_UART, `PC_PORT_MPU, `PC_PORT_VGA_B, `PC_PORT_VGA_C, `PC_PORT_VGA_D,
		`PC_PORT_SYSCTL};
	logic [7:0] mcodes [4] = '{`PC_MGMT_HDD0, `PC_MGMT_HDD1, `PC_MGMT_FDD0, `PC_MGMT_RTC};

	pc_io_hub dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic io_addr_t pick_addr();
		logic [31:0] r;
		r = next_rand();
		if (r[31:30] == 2'b00)
			return r[15:0];   // mostly unmapped space.
		return bases[r[4:0] % 24] + (r[12] ? {12'd0, r[11:8]} : 16'd0);
	endfunction

	task automatic drive_random();
		logic [31:0] r;
		r = next_rand();
		{floppy0_readdata, dma_readdata, pic_readdata, pit_readdata} <= r;
		r = next_rand();
		{ps2_readdata, rtc_readdata, sound_readdata, uart_readdata} <= r;
		r = next_rand();
		{vga_readdata, joy_readdata} <= r[15:0];
		{irq_0, irq_1, irq_2, irq_4, irq_5, irq_6, irq_8, irq_9, irq_12, irq_14, irq_15}
			<= r[26:16];
		hdd0_readdata      <= next_rand();
		hdd1_readdata      <= next_rand();
		mgmt_hdd0_readdata <= next_rand();
		mgmt_hdd1_readdata <= next_rand();
		mgmt_fdd0_readdata <= next_rand();
		r = next_rand();
		mgmt_ctl_address <= {r[2] ? r[31:24] : mcodes[r[1:0]], r[15:8]};
		mgmt_ctl_read    <= r[16];
		mgmt_ctl_write   <= r[17];
	endtask

	task automatic tick();
		@(posedge clk_sys);
		drive_random();
	endtask

	// address held 3 cycles, write strobe in the middle one.
	task automatic access(input io_addr_t addr, input logic wr, input io_size_t size,
		input io_data_t wdata);
		tick();
		iobus_address   <= addr;
		iobus_datasize  <= size;
		iobus_writedata <= wdata;
		tick();
		iobus_write <= wr;
		tick();
		iobus_write <= 1'b0;
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("Testbench failed");
		$fatal(1, "wait loop ran out of cycles");
	endtask

	task automatic wait_syscfg(input syscfg_t want);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (syscfg !== want) begin
			if (n == 20)
				stop_on_timeout("syscfg update");
			n++;
			tick();
			@(negedge clk_sys);
		end
	endtask

	always @(negedge clk_sys) begin
		if (dut0.asrt0.fail_count != 0) begin
			$display("ERR t=%0t %s got %h expected %h", $time, dut0.asrt0.fail_name,
				dut0.asrt0.fail_got, dut0.asrt0.fail_exp);
			$display("Testbench failed");
			$fatal(1, "assertion failure");
		end
	end

	initial begin
		logic [31:0] r;
		rng = 32'haaec404b;
		reset_cpu       <= 1'b1;
		iobus_address   <= '0;
		iobus_write     <= 1'b0;
		iobus_datasize  <= '0;
		iobus_writedata <= '0;
		drive_random();
		repeat (16) tick();
		reset_cpu <= 1'b0;
		access(`PC_PORT_HDD0, 1'b0, 3'd4, '0);   // first disk touch clears syscfg.
		wait_syscfg(8'h00);
		access(`PC_PORT_SYSCTL, 1'b1, 3'd2, {16'd0, `PC_SYSCFG_KEY, 8'h5C});
		wait_syscfg(8'h5C);
		access(`PC_PORT_SYSCTL, 1'b1, 3'd2, 32'h0000_3C33);   // no key.
		access(`PC_PORT_SYSCTL, 1'b1, 3'd4, {16'd0, `PC_SYSCFG_KEY, 8'h33});
		repeat (300) begin
			r = next_rand();
			access(pick_addr(), r[0], r[1] ? 3'd2 : r[4:2],
				{r[31:16], r[5] ? `PC_SYSCFG_KEY : r[15:8], r[13:6]});
		end
		tick();
		@(negedge clk_sys);
		if (dut0.asrt0.fail_count == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("Testbench failed");
			$fatal(1, "checks failed");
		end
	end

endmodule

// File: Bender.yml
package:
  name: pc_io_hub

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pc_io_pkg.sv
      - hdl/io_port_decode.sv
      - hdl/sysctl_port.sv
      - hdl/io_read_mux.sv
      - hdl/mgmt_target_decode.sv
      - hdl/pc_io_hub.sv
      - sim/pc_io_hub_asserts.sv
      - sim/tb_pc_io_hub.sv

// File: flist.f
+incdir+hdl
hdl/pc_io_pkg.sv
hdl/io_port_decode.sv
hdl/sysctl_port.sv
hdl/io_read_mux.sv
hdl/mgmt_target_decode.sv
hdl/pc_io_hub.sv
sim/pc_io_hub_asserts.sv
sim/tb_pc_io_hub.sv
